// File: rtl/pcxt_pkg.sv
// Shared definitions for the PC/XT glue logic
// Channel and sample widths, display mode encoding,
// splash and LED timing constants, luminance weight tables

`default_nettype none

package pcxt_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int COLOR_W  = 6;
	// Output channel is the colour value padded with two zero bits
	localparam int VGA_W    = 8;
	localparam int ASPECT_W = 13;
	localparam int OPL_W    = 16;
	localparam int TANDY_W  = 8;
	// One bit of headroom over the output
	localparam int MIX_W    = 17;
	localparam int AUDIO_W  = 16;

	// Video filter selection
	typedef enum logic [1:0] {
		DISP_COLOR = 2'd0,
		DISP_GREEN = 2'd1,
		DISP_AMBER = 2'd2,
		DISP_MONO  = 2'd3
	} display_mode_t;

	////////////////////////////////////////////////////////////
	// Timing
	////////////////////////////////////////////////////////////

	localparam int unsigned SPLASH_SECONDS      = 5;
	// One second at 50 MHz
	localparam int unsigned SPLASH_TICKS_DEFAULT = 50_000_000;
	localparam int unsigned LED_HOLD_DEFAULT     = 4_500_000;

	// Counter widths sized for the default values
	localparam int SPLASH_CNT_W = $clog2(SPLASH_TICKS_DEFAULT);
	localparam int SPLASH_SEC_W = $clog2(SPLASH_SECONDS + 1);
	localparam int LED_CNT_W    = $clog2(LED_HOLD_DEFAULT + 1);

	////////////////////////////////////////////////////////////
	// Luminance weights
	////////////////////////////////////////////////////////////

	localparam int WEIGHT_ENTRIES = 1 << COLOR_W;

	typedef logic [WEIGHT_ENTRIES-1:0][COLOR_W-1:0] weight_table_t;

	// Entry x is (x * factor + 128) / 256, fraction dropped
	function automatic weight_table_t build_weights(input int unsigned factor);
		weight_table_t tbl;
		tbl = '0;
		for (int i = 0; i < WEIGHT_ENTRIES; i++) begin
			tbl[i] = COLOR_W'((i * factor + 128) / 256);
		end
		return tbl;
	endfunction

	// Factors approximate 0.2126, 0.7152 and 0.0722 in 1/256 steps
	localparam weight_table_t RED_WEIGHT   = build_weights(54);
	localparam weight_table_t GREEN_WEIGHT = build_weights(183);
	localparam weight_table_t BLUE_WEIGHT  = build_weights(18);

endpackage

`default_nettype wire

// File: rtl/video_if.sv
// Video pixel bundle
// One RGB pixel with syncs and data enable, one per clock
// Source and sink views

`timescale 1ns/10ps
`default_nettype none

interface video_if;

	import pcxt_pkg::*;

	// Colour channels
	logic [COLOR_W-1:0] r;
	logic [COLOR_W-1:0] g;
	logic [COLOR_W-1:0] b;

	// Sync pulses and active area
	logic               hs;
	logic               vs;
	logic               de;

	// Producer side
	modport source (output r, g, b, hs, vs, de);

	// Consumer side
	modport sink (input r, g, b, hs, vs, de);

endinterface

`default_nettype wire

// File: rtl/core_control.sv
// Core control
// Splash hold timer and core reset
// Display mode and HDMI aspect ratio decode

`timescale 1ns/10ps
`default_nettype none

module core_control #(
	parameter int unsigned splash_ticks = pcxt_pkg::SPLASH_TICKS_DEFAULT
) (
	input  wire logic                            CLK_50M,
	input  wire logic                            reset,
	input  wire logic                            splash_skip,
	input  wire logic [1:0]                      mode_sel,
	input  wire logic [1:0]                      aspect_sel,
	output logic                                 core_reset,
	output pcxt_pkg::display_mode_t              display_mode,
	output logic [pcxt_pkg::ASPECT_W-1:0]        video_arx,
	output logic [pcxt_pkg::ASPECT_W-1:0]        video_ary
);

	import pcxt_pkg::*;

	////////////////////////////////////////////////////////////
	// Splash hold
	////////////////////////////////////////////////////////////

	logic [SPLASH_CNT_W-1:0] tick_cnt;
	logic [SPLASH_SEC_W-1:0] sec_cnt;
	logic                    hold;
	logic                    sec_done;
	logic                    last_sec;

	// End of one second of ticks
	assign sec_done = (tick_cnt == SPLASH_CNT_W'(splash_ticks - 1));
	// Final second about to complete
	assign last_sec = (sec_cnt == SPLASH_SEC_W'(SPLASH_SECONDS - 1));

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			tick_cnt <= '0;
			sec_cnt  <= '0;
			hold     <= 1'b1;
		end else if (hold) begin
			// Skip level ends the hold at once
			if (splash_skip) begin
				hold <= 1'b0;
			end else if (sec_done) begin
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 1'b1;
				// Drop on the edge that completes the last second
				if (last_sec) begin
					hold <= 1'b0;
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// Core stays held through reset and the splash time
	assign core_reset = reset | hold;

	// Hold only comes back through reset
	assert property (@(posedge CLK_50M) disable iff (reset) !hold |=> !hold)
		else $error("splash hold set again without reset");

	////////////////////////////////////////////////////////////
	// Mode and aspect decode
	////////////////////////////////////////////////////////////

	assign display_mode = display_mode_t'(mode_sel);

	always_comb begin
		if (aspect_sel == 2'd0) begin
			// Original 4:3
			video_arx = ASPECT_W'(4);
			video_ary = ASPECT_W'(3);
		end else begin
			// Full screen and the two custom ratios
			video_arx = ASPECT_W'(aspect_sel) - ASPECT_W'(1);
			video_ary = '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mono_palette.sv
// Monochrome palette filter
// Colour pass-through or luminance shown as green, amber or grey
// One register stage on pixel, syncs and enable

`timescale 1ns/10ps
`default_nettype none

module mono_palette (
	input  wire logic                    CLK_50M,
	input  wire logic                    reset,
	input  wire pcxt_pkg::display_mode_t display_mode,
	video_if.sink                        pix_in,
	video_if.source                      pix_out
);

	import pcxt_pkg::*;

	////////////////////////////////////////////////////////////
	// Luminance
	////////////////////////////////////////////////////////////

	logic [COLOR_W-1:0] luma;

	// Weighted sum of the three channels
	// Table maxima 13 + 45 + 4 fit in six bits
	assign luma = RED_WEIGHT[pix_in.r] + GREEN_WEIGHT[pix_in.g] + BLUE_WEIGHT[pix_in.b];

	////////////////////////////////////////////////////////////
	// Channel select
	////////////////////////////////////////////////////////////

	logic [COLOR_W-1:0] r_next;
	logic [COLOR_W-1:0] g_next;
	logic [COLOR_W-1:0] b_next;

	always_comb begin
		case (display_mode)
			DISP_GREEN: begin
				r_next = '0;
				g_next = luma;
				b_next = '0;
			end
			DISP_AMBER: begin
				// Amber tint from half green
				r_next = luma;
				g_next = luma >> 1;
				b_next = '0;
			end
			DISP_MONO: begin
				r_next = luma;
				g_next = luma;
				b_next = luma;
			end
			default: begin
				// Colour passes through
				r_next = pix_in.r;
				g_next = pix_in.g;
				b_next = pix_in.b;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	logic [COLOR_W-1:0] r_q;
	logic [COLOR_W-1:0] g_q;
	logic [COLOR_W-1:0] b_q;
	logic               hs_q;
	logic               vs_q;
	logic               de_q;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			r_q  <= '0;
			g_q  <= '0;
			b_q  <= '0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			de_q <= 1'b0;
		end else begin
			r_q  <= r_next;
			g_q  <= g_next;
			b_q  <= b_next;
			// Syncs delayed to stay aligned with the pixel
			hs_q <= pix_in.hs;
			vs_q <= pix_in.vs;
			de_q <= pix_in.de;
		end
	end

	assign pix_out.r  = r_q;
	assign pix_out.g  = g_q;
	assign pix_out.b  = b_q;
	assign pix_out.hs = hs_q;
	assign pix_out.vs = vs_q;
	assign pix_out.de = de_q;

	// Tinted modes carry no blue
	assert property (@(posedge CLK_50M) disable iff (reset)
		(display_mode inside {DISP_GREEN, DISP_AMBER}) |=> (b_q == '0))
		else $error("blue channel set in green or amber mode");

endmodule

`default_nettype wire

// File: rtl/audio_mixer.sv
// Audio mixer
// Signed sum of OPL2, PC speaker and Tandy sources
// Registered, halved to the output width

`timescale 1ns/10ps
`default_nettype none

module audio_mixer (
	input  wire logic                                 CLK_50M,
	input  wire logic                                 reset,
	input  wire logic signed [pcxt_pkg::OPL_W-1:0]    opl_sample,
	input  wire logic                                 speaker,
	input  wire logic [pcxt_pkg::TANDY_W-1:0]         tandy_sample,
	output logic [pcxt_pkg::AUDIO_W-1:0]              audio_out
);

	import pcxt_pkg::*;

	logic [MIX_W-1:0] opl_term;
	logic [MIX_W-1:0] spk_term;
	logic [MIX_W-1:0] tandy_term;
	logic [MIX_W-1:0] mix_sum;

	// OPL sign-extended, then times 4
	assign opl_term   = {opl_sample[OPL_W-1], opl_sample} << 2;
	// Speaker bit lands at 32768
	assign spk_term   = {1'b0, speaker, 15'd0};
	// Tandy times 256
	assign tandy_term = {1'b0, tandy_sample, 8'd0};

	// Wraps in MIX_W bits
	assign mix_sum = opl_term + spk_term + tandy_term;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			audio_out <= '0;
		end else begin
			audio_out <= mix_sum[MIX_W-1:1];
		end
	end

endmodule

`default_nettype wire

// File: rtl/activity_led.sv
// Activity LED
// Pulse stretcher, retriggered by every activity pulse

`timescale 1ns/10ps
`default_nettype none

module activity_led #(
	parameter int unsigned hold_cycles = pcxt_pkg::LED_HOLD_DEFAULT
) (
	input  wire logic CLK_50M,
	input  wire logic reset,
	input  wire logic activity,
	output logic      led
);

	import pcxt_pkg::*;

	logic [LED_CNT_W-1:0] hold_cnt;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			hold_cnt <= '0;
		end else if (activity) begin
			// Restart the stretch on each pulse
			hold_cnt <= LED_CNT_W'(hold_cycles);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Lit while counting down
	assign led = (hold_cnt != '0);

	// Idle counter with no pulse keeps the LED dark
	assert property (@(posedge CLK_50M) disable iff (reset)
		(hold_cnt == '0 && !activity) |=> !led)
		else $error("LED lit without activity");

endmodule

`default_nettype wire

// File: rtl/pcxt_top.sv
// PC/XT glue top level
// Plain ports mapped onto pixel bundles
// Control, palette filter, audio mixer and activity LED

`timescale 1ns/10ps
`default_nettype none

module pcxt_top #(
	parameter int unsigned splash_ticks = pcxt_pkg::SPLASH_TICKS_DEFAULT,
	parameter int unsigned hold_cycles  = pcxt_pkg::LED_HOLD_DEFAULT
) (
	input  wire logic                                CLK_50M,
	input  wire logic                                reset,
	input  wire logic                                splash_skip,
	input  wire logic [1:0]                          mode_sel,
	input  wire logic [1:0]                          aspect_sel,
	input  wire logic [pcxt_pkg::COLOR_W-1:0]        r_in,
	input  wire logic [pcxt_pkg::COLOR_W-1:0]        g_in,
	input  wire logic [pcxt_pkg::COLOR_W-1:0]        b_in,
	input  wire logic                                hs_in,
	input  wire logic                                vs_in,
	input  wire logic                                de_in,
	input  wire logic signed [pcxt_pkg::OPL_W-1:0]   opl_sample,
	input  wire logic                                speaker,
	input  wire logic [pcxt_pkg::TANDY_W-1:0]        tandy_sample,
	input  wire logic                                disk_activity,
	output logic                                     core_reset,
	output logic [pcxt_pkg::VGA_W-1:0]               vga_r,
	output logic [pcxt_pkg::VGA_W-1:0]               vga_g,
	output logic [pcxt_pkg::VGA_W-1:0]               vga_b,
	output logic                                     vga_hs,
	output logic                                     vga_vs,
	output logic                                     vga_de,
	output logic [pcxt_pkg::AUDIO_W-1:0]             audio_l,
	output logic [pcxt_pkg::AUDIO_W-1:0]             audio_r,
	output logic                                     led_user,
	output logic [pcxt_pkg::ASPECT_W-1:0]            video_arx,
	output logic [pcxt_pkg::ASPECT_W-1:0]            video_ary
);

	import pcxt_pkg::*;

	////////////////////////////////////////////////////////////
	// Video path
	////////////////////////////////////////////////////////////

	video_if       vid_in ();
	video_if       vid_out ();
	display_mode_t display_mode;
	logic [AUDIO_W-1:0] audio_mix;

	// Raw pixel from the video source
	assign vid_in.r  = r_in;
	assign vid_in.g  = g_in;
	assign vid_in.b  = b_in;
	assign vid_in.hs = hs_in;
	assign vid_in.vs = vs_in;
	assign vid_in.de = de_in;

	// 6-bit channels padded to the 8-bit VGA outputs
	assign vga_r  = {vid_out.r, {(VGA_W - COLOR_W){1'b0}}};
	assign vga_g  = {vid_out.g, {(VGA_W - COLOR_W){1'b0}}};
	assign vga_b  = {vid_out.b, {(VGA_W - COLOR_W){1'b0}}};
	assign vga_hs = vid_out.hs;
	assign vga_vs = vid_out.vs;
	assign vga_de = vid_out.de;

	core_control #(.splash_ticks(splash_ticks)) u_core_control (
		.CLK_50M      (CLK_50M),
		.reset        (reset),
		.splash_skip  (splash_skip),
		.mode_sel     (mode_sel),
		.aspect_sel   (aspect_sel),
		.core_reset   (core_reset),
		.display_mode (display_mode),
		.video_arx    (video_arx),
		.video_ary    (video_ary)
	);

	mono_palette u_mono_palette (
		.CLK_50M      (CLK_50M),
		.reset        (reset),
		.display_mode (display_mode),
		.pix_in       (vid_in.sink),
		.pix_out      (vid_out.source)
	);

	////////////////////////////////////////////////////////////
	// Audio and LED
	////////////////////////////////////////////////////////////

	audio_mixer u_audio_mixer (
		.CLK_50M      (CLK_50M),
		.reset        (reset),
		.opl_sample   (opl_sample),
		.speaker      (speaker),
		.tandy_sample (tandy_sample),
		.audio_out    (audio_mix)
	);

	// Mono mix on both channels
	assign audio_l = audio_mix;
	assign audio_r = audio_mix;

	activity_led #(.hold_cycles(hold_cycles)) u_activity_led (
		.CLK_50M  (CLK_50M),
		.reset    (reset),
		.activity (disk_activity),
		.led      (led_user)
	);

endmodule

`default_nettype wire

// File: dv/tb_ref.svh
// Reference model for the PC/XT glue testbench
// Luminance weights, pixel filter, audio mix and aspect decode

`ifndef TB_REF_SVH
`define TB_REF_SVH

// One weight entry rounded then truncated
function automatic int weight_entry(input int x, input int factor);
	return (x * factor + 128) / 256;
endfunction

// Y as the sum of the three weighted channels
function automatic int luminance(input logic [5:0] r, input logic [5:0] g,
		input logic [5:0] b);
	return weight_entry(int'(r), 54) + weight_entry(int'(g), 183)
		+ weight_entry(int'(b), 18);
endfunction

// Filtered pixel packed as {r, g, b}
function automatic logic [17:0] filtered_pixel(input logic [1:0] mode, input logic [5:0] r,
		input logic [5:0] g, input logic [5:0] b);
	int y;
	y = luminance(r, g, b);
	case (mode)
		DISP_GREEN: return {6'd0, 6'(y), 6'd0};
		// Green at half of Y gives the amber tint
		DISP_AMBER: return {6'(y), 6'(y / 2), 6'd0};
		DISP_MONO:  return {6'(y), 6'(y), 6'(y)};
		default:    return {r, g, b};
	endcase
endfunction

// Sum of the three sources in 17 bits then halved
function automatic logic [15:0] mixed_audio(input logic signed [15:0] opl, input logic spk,
		input logic [7:0] tandy);
	int total;
	int o;
	int s;
	int t;
	o = opl;
	s = spk;
	t = tandy;
	total = o * 4 + s * 32768 + t * 256;
	return total[16:1];
endfunction

// Packed as {arx, ary}
function automatic logic [25:0] decoded_aspect(input logic [1:0] sel);
	if (sel == 2'd0) begin
		return {13'd4, 13'd3};
	end
	return {13'(sel) - 13'd1, 13'd0};
endfunction

`endif

// File: dv/tb_pcxt_top.sv
// Testbench for the PC/XT glue top level
// Clock, reset, random stimulus, compare process, checker and watchdog

`timescale 1ns/10ps
`default_nettype none

module tb_pcxt_top #(
	parameter int rand_seed = 29502
);

	import pcxt_pkg::*;

	`include "tb_ref.svh"

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 8;
	localparam int SPLASH_TB    = 10;
	localparam int HOLD_TB      = 6;
	localparam int SPLASH_EDGES = SPLASH_SECONDS * SPLASH_TB;
	localparam int RAND_CYCLES  = 200;
	// Reset runs, splash, four pixel phases, audio, aspect, LED
	localparam int TOTAL_CYCLES = 2 * (RESET_CYCLES + 2) + SPLASH_EDGES + 5
		+ 4 * (RAND_CYCLES + 3) + 8 + 4 + 24;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

	logic CLK_50M, reset, splash_skip, hs_in, vs_in, de_in, speaker, disk_activity;
	logic [1:0] mode_sel;
	logic [1:0] aspect_sel;
	logic [COLOR_W-1:0] r_in, g_in, b_in;
	logic signed [OPL_W-1:0] opl_sample;
	logic [TANDY_W-1:0] tandy_sample;
	logic core_reset, vga_hs, vga_vs, vga_de, led_user;
	logic [VGA_W-1:0] vga_r, vga_g, vga_b;
	logic [AUDIO_W-1:0] audio_l, audio_r;
	logic [ASPECT_W-1:0] video_arx, video_ary;

	integer seed;
	integer error_count = 0;

	// Inputs seen at the previous falling edge
	logic prev_valid = 1'b0;
	logic prev_reset, prev_hs, prev_vs, prev_de, prev_spk;
	logic [1:0] prev_mode;
	logic [5:0] prev_r, prev_g, prev_b;
	logic signed [15:0] prev_opl;
	logic [7:0] prev_tandy;

	pcxt_top #(.splash_ticks(SPLASH_TB), .hold_cycles(HOLD_TB)) dut (.*);

	initial begin
		CLK_50M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;
	end

	////////////////////////////////////////////////////////////
	// Checker and drivers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			error_count = error_count + 1;
			$display("FAIL %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// Reset held for RESET_CYCLES edges with the skip level alongside
	task automatic apply_reset(input logic skip);
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		reset = 1'b1;
		splash_skip = skip;
		repeat (RESET_CYCLES) @(posedge CLK_50M);
		#DRIVE_DELAY;
		reset = 1'b0;
	endtask

	task automatic drive_pixel(input logic [5:0] r, input logic [5:0] g, input logic [5:0] b);
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		r_in = r;
		g_in = g;
		b_in = b;
	endtask

	task automatic drive_audio(input logic signed [15:0] opl, input logic spk,
			input logic [7:0] tandy);
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		opl_sample = opl;
		speaker = spk;
		tandy_sample = tandy;
	endtask

	// Random pixel, syncs and audio every cycle
	task automatic run_random(input int cycles);
		logic [31:0] rnd;
		repeat (cycles) begin
			@(posedge CLK_50M);
			#DRIVE_DELAY;
			rnd = $random(seed);
			{r_in, g_in, b_in, hs_in, vs_in, de_in} = rnd[20:0];
			rnd = $random(seed);
			{opl_sample, tandy_sample, speaker} = rnd[24:0];
		end
	endtask

	// Sample LED after the next edge
	task automatic led_after_edge(input logic exp);
		@(posedge CLK_50M);
		@(negedge CLK_50M);
		check_value("led_user", led_user, exp);
	endtask

	////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////

	always @(negedge CLK_50M) begin : compare_outputs
		logic [17:0] exp_pix;
		logic [25:0] exp_asp;
		logic [15:0] exp_mix;
		exp_asp = decoded_aspect(aspect_sel);
		check_value("video_arx", video_arx, exp_asp[25:13]);
		check_value("video_ary", video_ary, exp_asp[12:0]);
		if (reset) begin
			check_value("core_reset", core_reset, 1);
		end
		if (prev_valid) begin
			// Reset on the last edge clears every register
			exp_pix = prev_reset ? '0 : filtered_pixel(prev_mode, prev_r, prev_g, prev_b);
			exp_mix = prev_reset ? '0 : mixed_audio(prev_opl, prev_spk, prev_tandy);
			check_value("vga_r", vga_r, {exp_pix[17:12], 2'b00});
			check_value("vga_g", vga_g, {exp_pix[11:6], 2'b00});
			check_value("vga_b", vga_b, {exp_pix[5:0], 2'b00});
			check_value("vga_hs", vga_hs, prev_reset ? 0 : prev_hs);
			check_value("vga_vs", vga_vs, prev_reset ? 0 : prev_vs);
			check_value("vga_de", vga_de, prev_reset ? 0 : prev_de);
			check_value("audio_l", audio_l, exp_mix);
			check_value("audio_r", audio_r, exp_mix);
			if (prev_reset) begin
				check_value("led_user", led_user, 0);
			end
		end
		prev_valid = 1'b1;
		prev_reset = reset;
		prev_mode = mode_sel;
		{prev_r, prev_g, prev_b} = {r_in, g_in, b_in};
		{prev_hs, prev_vs, prev_de} = {hs_in, vs_in, de_in};
		{prev_opl, prev_spk, prev_tandy} = {opl_sample, speaker, tandy_sample};
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin : main_sequence
		seed = rand_seed;
		reset = 1'b1;
		splash_skip = 1'b0;
		mode_sel = 2'd0;
		aspect_sel = 2'd0;
		{r_in, g_in, b_in, hs_in, vs_in, de_in} = '0;
		{opl_sample, speaker, tandy_sample} = '0;
		disk_activity = 1'b0;

		// Splash hold runs its full length
		apply_reset(1'b0);
		@(negedge CLK_50M);
		check_value("core_reset", core_reset, 1);
		for (int n = 1; n < SPLASH_EDGES; n++) begin
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			check_value("core_reset", core_reset, 1);
		end
		@(posedge CLK_50M);
		@(negedge CLK_50M);
		check_value("core_reset", core_reset, 0);

		// Skip level cuts the hold short
		apply_reset(1'b1);
		repeat (2) @(posedge CLK_50M);
		@(negedge CLK_50M);
		check_value("core_reset", core_reset, 0);
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		splash_skip = 1'b0;

		// Colour mode then the three luminance modes with corner pixels
		run_random(RAND_CYCLES);
		for (int m = 1; m < 4; m++) begin
			@(posedge CLK_50M);
			#DRIVE_DELAY;
			mode_sel = 2'(m);
			drive_pixel(6'd63, 6'd63, 6'd63);
			drive_pixel(6'd0, 6'd0, 6'd0);
			run_random(RAND_CYCLES);
		end

		// Audio extremes
		drive_audio(-16'sd32768, 1'b1, 8'd255);
		drive_audio(16'sd32767, 1'b1, 8'd255);
		drive_audio(-16'sd32768, 1'b0, 8'd0);
		drive_audio(16'sd32767, 1'b0, 8'd255);
		drive_audio(16'sd0, 1'b1, 8'd0);
		drive_audio(-16'sd1, 1'b0, 8'd255);

		// All aspect selections for the compare process
		for (int s = 0; s < 4; s++) begin
			@(posedge CLK_50M);
			#DRIVE_DELAY;
			aspect_sel = 2'(s);
		end

		// Single activity pulse
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		disk_activity = 1'b1;
		@(negedge CLK_50M);
		check_value("led_user", led_user, 0);
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		disk_activity = 1'b0;
		@(negedge CLK_50M);
		check_value("led_user", led_user, 1);
		repeat (HOLD_TB - 1) led_after_edge(1'b1);
		led_after_edge(1'b0);

		// Second pulse three edges in restarts the count
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		disk_activity = 1'b1;
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		disk_activity = 1'b0;
		repeat (2) @(posedge CLK_50M);
		#DRIVE_DELAY;
		disk_activity = 1'b1;
		@(posedge CLK_50M);
		#DRIVE_DELAY;
		disk_activity = 1'b0;
		@(negedge CLK_50M);
		check_value("led_user", led_user, 1);
		repeat (HOLD_TB - 1) led_after_edge(1'b1);
		led_after_edge(1'b0);

		repeat (4) @(posedge CLK_50M);
		@(negedge CLK_50M);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$fatal(1, "%0d mismatches", error_count);
		end
	end

	// Run length bound from the test lengths
	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns before the tests finished", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+dv
rtl/pcxt_pkg.sv
rtl/video_if.sv
rtl/core_control.sv
rtl/mono_palette.sv
rtl/audio_mixer.sv
rtl/activity_led.sv
rtl/pcxt_top.sv
dv/tb_pcxt_top.sv

// File: Makefile
# Verilator build and run for the PC/XT glue testbench

TOP       ?= tb_pcxt_top
SEED      ?= 29502
LOG       ?= sim.log
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Grand_seed=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
